// ==== list.f ====
+incdir+.
cpu_isa_pkg.sv
cpu_core_pkg.sv
cpu_decode.sv
cpu_regfile.sv
cpu_bus_master.sv
cpu_ctrl.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_cpu -f list.f --Mdir obj_dir -o tb_cpu

run: compile
	-./obj_dir/tb_cpu > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu;

  // padding fetches watched after the program so that a stray write shows in the count.
  localparam int tail_fetches = 4;

  logic               i_clk;
  logic               i_rst;
  logic               o_mem_req;
  logic               mem_ack;
  logic               o_mem_we;
  cpu_isa_pkg::word_t o_mem_addr;
  cpu_isa_pkg::byte_t o_mem_wdata;
  cpu_isa_pkg::byte_t mem_rdata;

  cpu_isa_pkg::byte_t image   [0:65535];
  cpu_isa_pkg::byte_t mem     [0:65535];
  cpu_isa_pkg::byte_t ref_mem [0:65535];

  logic               exp_we   [$];
  cpu_isa_pkg::word_t exp_addr [$];
  cpu_isa_pkg::byte_t exp_data [$];
  int                 exp_total;
  int                 exp_writes;
  int                 seen;
  int                 writes_seen;

  logic [15:0]        lfsr_state;
  cpu_isa_pkg::word_t load_addr;
  cpu_isa_pkg::word_t prog_end;
  logic               pending;
  cpu_isa_pkg::byte_t delay;
  logic               held_req;
  logic               held_we;
  cpu_isa_pkg::word_t held_addr;
  cpu_isa_pkg::byte_t held_wdata;

  cpu_top uut (
    .i_clk(i_clk), .i_rst(i_rst),
    .o_mem_req(o_mem_req), .i_mem_ack(mem_ack), .o_mem_we(o_mem_we),
    .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(mem_rdata)
  );

  always #5 i_clk = ~i_clk;

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input cpu_isa_pkg::byte_t got,
                            input cpu_isa_pkg::byte_t exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input cpu_isa_pkg::word_t got,
                            input cpu_isa_pkg::word_t exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // 16-bit fibonacci lfsr with taps 16 14 13 11.
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic cpu_isa_pkg::byte_t draw_byte(input int nbits);
    cpu_isa_pkg::byte_t v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v = {v[6:0], lfsr_step()};
    end
    return v;
  endfunction

  // stores land in 0xc000 and up, preloaded data in 0x8000 to 0xbfff.
  function automatic cpu_isa_pkg::byte_t store_page();
    return 8'hC0 | draw_byte(6);
  endfunction

  function automatic cpu_isa_pkg::byte_t data_page();
    return 8'h80 | draw_byte(6);
  endfunction

  task automatic emit(input cpu_isa_pkg::byte_t b);
    image[load_addr] = b;
    load_addr = load_addr + 16'd1;
  endtask

  task automatic store_a();
    emit(8'hEA);
    emit(draw_byte(8));
    emit(store_page());
  endtask

  task automatic build_program();
    cpu_isa_pkg::word_t nn;
    load_addr = `CPU_RESET_PC;
    for (int round = 0; round < 4; round++) begin
      // load each register and store it through a fresh HL.
      for (int ri = 0; ri < 8; ri++) begin
        if (ri != 6) begin
          emit(8'h21);
          emit(draw_byte(8));
          emit(store_page());
          emit({2'b00, 3'(ri), 3'b110});
          emit(ri == 4 ? store_page() : draw_byte(8));
          emit({5'b01110, 3'(ri)});
        end
      end
      // wrap cases and then a copy chain through INC and DEC.
      emit(8'h06); emit(8'hFF); emit(8'h04); emit(8'h78); store_a();
      emit(8'h0E); emit(8'h00); emit(8'h0D); emit(8'h79); store_a();
      emit(8'h16); emit(draw_byte(8)); emit(8'h5A); emit(8'h4B); emit(8'h79);
      emit(8'h3C); store_a();
      emit(8'h1C); emit(8'h7B); emit(8'h3D); emit(8'h3D); store_a();
      // reads of preloaded bytes.
      nn = {data_page(), draw_byte(8)};
      image[nn] = draw_byte(8);
      emit(8'hFA); emit(nn[7:0]); emit(nn[15:8]); store_a();
      nn = {data_page(), draw_byte(8)};
      image[nn] = draw_byte(8);
      emit(8'h21); emit(nn[7:0]); emit(nn[15:8]); emit(8'h5E);
      emit(8'h21); emit(draw_byte(8)); emit(store_page()); emit(8'h73);
      // dropped opcodes fall through as single fetches.
      emit(8'h31); emit(8'h34); emit(8'h76); emit(8'h0B); emit(8'h22); emit(8'hE0);
      emit(8'h36); emit(draw_byte(8)); store_a();
    end
    prog_end = load_addr;
  endtask

  function automatic cpu_isa_pkg::byte_t expect_read(input cpu_isa_pkg::word_t addr);
    exp_we.push_back(1'b0);
    exp_addr.push_back(addr);
    exp_data.push_back(8'h00);
    return ref_mem[addr];
  endfunction

  function automatic void expect_write(input cpu_isa_pkg::word_t addr,
                                       input cpu_isa_pkg::byte_t data);
    exp_we.push_back(1'b1);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    ref_mem[addr] = data;
    exp_writes++;
  endfunction

  // instruction-level model that returns the number of bus transfers.
  function automatic int build_expected();
    cpu_isa_pkg::byte_t r [8];
    cpu_isa_pkg::word_t pc;
    cpu_isa_pkg::word_t hl;
    cpu_isa_pkg::word_t nn;
    cpu_isa_pkg::byte_t opc;
    cpu_isa_pkg::byte_t n;
    logic [2:0]         dst;
    logic [2:0]         src;
    for (int i = 0; i < 8; i++) begin
      r[i] = 8'h00;
    end
    pc = `CPU_RESET_PC;
    while (pc < prog_end) begin
      opc = expect_read(pc);
      pc  = pc + 16'd1;
      dst = opc[5:3];
      src = opc[2:0];
      hl  = {r[4], r[5]};
      if (opc[7:6] == 2'b01 && opc != 8'h76) begin
        if (src == 3'd6) r[dst] = expect_read(hl);
        else if (dst == 3'd6) expect_write(hl, r[src]);
        else r[dst] = r[src];
      end else if (opc[7:6] == 2'b00 && src == 3'd6) begin
        n  = expect_read(pc);
        pc = pc + 16'd1;
        if (dst == 3'd6) expect_write(hl, n);
        else r[dst] = n;
      end else if (opc[7:6] == 2'b00 && src == 3'd4 && dst != 3'd6) begin
        r[dst] = r[dst] + 8'd1;
      end else if (opc[7:6] == 2'b00 && src == 3'd5 && dst != 3'd6) begin
        r[dst] = r[dst] - 8'd1;
      end else if (opc[7:6] == 2'b00 && opc[3:0] == 4'h1 && opc[5:4] != 2'd3) begin
        nn[7:0]  = expect_read(pc);
        nn[15:8] = expect_read(pc + 16'd1);
        pc       = pc + 16'd2;
        r[{opc[5:4], 1'b0}] = nn[15:8];
        r[{opc[5:4], 1'b1}] = nn[7:0];
      end else if (opc == 8'hFA || opc == 8'hEA) begin
        nn[7:0]  = expect_read(pc);
        nn[15:8] = expect_read(pc + 16'd1);
        pc       = pc + 16'd2;
        if (opc == 8'hFA) r[7] = expect_read(nn);
        else expect_write(nn, r[7]);
      end
    end
    return exp_addr.size();
  endfunction

  // memory responder with a random ack delay of 0 to 3 cycles.
  always @(negedge i_clk) begin
    if (mem_ack) begin
      if (!o_mem_req) mem_ack = 1'b0;
    end else if (o_mem_req) begin
      if (!pending) begin
        delay   = draw_byte(2);
        pending = 1'b1;
      end
      if (delay == 8'd0) begin
        if (o_mem_we) mem[o_mem_addr] = o_mem_wdata;
        else mem_rdata = mem[o_mem_addr];
        mem_ack = 1'b1;
        pending = 1'b0;
      end else begin
        delay = delay - 8'd1;
      end
    end
  end

  // transfer checker that samples the bus on the rising edge.
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (o_mem_req && held_req) begin
        check_word("o_mem_addr", o_mem_addr, held_addr);
        check_bit("o_mem_we", o_mem_we, held_we);
        check_byte("o_mem_wdata", o_mem_wdata, held_wdata);
      end
      held_addr  = o_mem_addr;
      held_we    = o_mem_we;
      held_wdata = o_mem_wdata;
      held_req   = o_mem_req && !mem_ack;
      if (o_mem_req && mem_ack) begin
        if (o_mem_we) begin
          writes_seen++;
        end
        if (seen < exp_total) begin
          check_bit("o_mem_we", o_mem_we, exp_we[seen]);
          check_word("o_mem_addr", o_mem_addr, exp_addr[seen]);
          if (o_mem_we) begin
            check_byte("o_mem_wdata", o_mem_wdata, exp_data[seen]);
          end
        end
        seen++;
      end
    end
  end

  initial begin
    int cycles;
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    mem_ack     = 1'b0;
    mem_rdata   = 8'h00;
    pending     = 1'b0;
    delay       = 8'h00;
    held_req    = 1'b0;
    seen        = 0;
    writes_seen = 0;
    exp_writes  = 0;
    lfsr_state  = 16'h0001;
    for (int i = 0; i < 65536; i++) begin
      image[i] = 8'h00;
    end
    build_program();
    for (int i = 0; i < 65536; i++) begin
      mem[i]     = image[i];
      ref_mem[i] = image[i];
    end
    exp_total = build_expected();
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    check_bit("o_mem_req", o_mem_req, 1'b0);
    check_bit("o_mem_we", o_mem_we, 1'b0);
    i_rst  = 1'b0;
    cycles = 0;
    while (seen < exp_total + tail_fetches && cycles < 50000) begin
      @(negedge i_clk);
      cycles++;
    end
    if (seen < exp_total + tail_fetches) begin
      $display("timeout: only %0d of %0d bus transfers completed",
               seen, exp_total + tail_fetches);
      abort_run();
    end else if (writes_seen == exp_writes) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("FAILED write count got 0x%h expected 0x%h", writes_seen, exp_writes);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire                i_clk,
  input  wire                i_rst,
  output logic               o_mem_req,
  input  wire                i_mem_ack,
  output logic               o_mem_we,
  output cpu_isa_pkg::word_t o_mem_addr,
  output cpu_isa_pkg::byte_t o_mem_wdata,
  input  cpu_isa_pkg::byte_t i_mem_rdata
);

  logic                   bus_start;
  logic                   bus_we;
  cpu_isa_pkg::word_t     bus_addr;
  cpu_isa_pkg::byte_t     bus_wdata;
  logic                   bus_done;
  cpu_isa_pkg::byte_t     bus_rdata;
  cpu_isa_pkg::byte_t     opcode;
  cpu_isa_pkg::op_t       op;
  cpu_isa_pkg::reg_idx_t  dst;
  cpu_isa_pkg::reg_idx_t  src;
  cpu_isa_pkg::pair_idx_t pair;
  cpu_isa_pkg::reg_idx_t  rd_a_sel;
  cpu_isa_pkg::reg_idx_t  rd_b_sel;
  cpu_isa_pkg::byte_t     rd_a;
  cpu_isa_pkg::byte_t     rd_b;
  cpu_isa_pkg::word_t     hl;
  logic                   wr_en;
  cpu_isa_pkg::reg_idx_t  wr_sel;
  cpu_isa_pkg::byte_t     wr_data;
  logic                   pair_wr_en;
  cpu_isa_pkg::pair_idx_t pair_sel;
  cpu_isa_pkg::word_t     pair_wr_data;

  cpu_ctrl u_ctrl (
    .i_clk(i_clk), .i_rst(i_rst),
    .o_start(bus_start), .o_we(bus_we), .o_addr(bus_addr), .o_wdata(bus_wdata),
    .i_done(bus_done), .i_rdata(bus_rdata),
    .o_opcode(opcode), .i_op(op), .i_dst(dst), .i_src(src), .i_pair(pair),
    .o_rd_a_sel(rd_a_sel), .o_rd_b_sel(rd_b_sel),
    .i_rd_a(rd_a), .i_rd_b(rd_b), .i_hl(hl),
    .o_wr_en(wr_en), .o_wr_sel(wr_sel), .o_wr_data(wr_data),
    .o_pair_wr_en(pair_wr_en), .o_pair_sel(pair_sel), .o_pair_wr_data(pair_wr_data)
  );

  cpu_decode u_decode (
    .i_opcode(opcode), .o_op(op), .o_dst(dst), .o_src(src), .o_pair(pair)
  );

  cpu_regfile u_regfile (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rd_a_sel(rd_a_sel), .i_rd_b_sel(rd_b_sel),
    .i_wr_en(wr_en), .i_wr_sel(wr_sel), .i_wr_data(wr_data),
    .i_pair_wr_en(pair_wr_en), .i_pair_sel(pair_sel), .i_pair_wr_data(pair_wr_data),
    .o_rd_a(rd_a), .o_rd_b(rd_b), .o_hl(hl)
  );

  cpu_bus_master u_bus_master (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_start(bus_start), .i_we(bus_we), .i_addr(bus_addr), .i_wdata(bus_wdata),
    .o_done(bus_done), .o_rdata(bus_rdata),
    .o_mem_req(o_mem_req), .i_mem_ack(i_mem_ack), .o_mem_we(o_mem_we),
    .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata)
  );

endmodule

`default_nettype wire

// ==== cpu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_ctrl (
  input  wire                    i_clk,
  input  wire                    i_rst,
  output logic                   o_start,
  output logic                   o_we,
  output cpu_isa_pkg::word_t     o_addr,
  output cpu_isa_pkg::byte_t     o_wdata,
  input  wire                    i_done,
  input  cpu_isa_pkg::byte_t     i_rdata,
  output cpu_isa_pkg::byte_t     o_opcode,
  input  cpu_isa_pkg::op_t       i_op,
  input  cpu_isa_pkg::reg_idx_t  i_dst,
  input  cpu_isa_pkg::reg_idx_t  i_src,
  input  cpu_isa_pkg::pair_idx_t i_pair,
  output cpu_isa_pkg::reg_idx_t  o_rd_a_sel,
  output cpu_isa_pkg::reg_idx_t  o_rd_b_sel,
  input  cpu_isa_pkg::byte_t     i_rd_a,
  input  cpu_isa_pkg::byte_t     i_rd_b,
  input  cpu_isa_pkg::word_t     i_hl,
  output logic                   o_wr_en,
  output cpu_isa_pkg::reg_idx_t  o_wr_sel,
  output cpu_isa_pkg::byte_t     o_wr_data,
  output logic                   o_pair_wr_en,
  output cpu_isa_pkg::pair_idx_t o_pair_sel,
  output cpu_isa_pkg::word_t     o_pair_wr_data
);

  cpu_core_pkg::ctrl_state_t state;
  cpu_isa_pkg::word_t        pc;
  cpu_isa_pkg::byte_t        ir;
  cpu_isa_pkg::byte_t        imm_lo;
  cpu_isa_pkg::byte_t        imm_hi;
  logic                      busy;
  logic                      xfer_state;
  logic                      direct_addr;
  logic                      store_op;

  assign xfer_state = (state == cpu_core_pkg::S_FETCH) || (state == cpu_core_pkg::S_IMM) ||
                      (state == cpu_core_pkg::S_IMM_LO) || (state == cpu_core_pkg::S_IMM_HI) ||
                      (state == cpu_core_pkg::S_MEM);

  assign direct_addr = (i_op == cpu_isa_pkg::OP_LD_A_NN) || (i_op == cpu_isa_pkg::OP_LD_NN_A);
  assign store_op    = (i_op == cpu_isa_pkg::OP_LD_HL_R) || (i_op == cpu_isa_pkg::OP_LD_HL_N) ||
                       (i_op == cpu_isa_pkg::OP_LD_NN_A);

  // one transfer per transfer state is issued on entry.
  assign o_start = xfer_state && !busy;
  assign o_we    = (state == cpu_core_pkg::S_MEM) && store_op;

  always_comb begin
    if (state != cpu_core_pkg::S_MEM) begin
      o_addr = pc;
    end else if (direct_addr) begin
      o_addr = {imm_hi, imm_lo};
    end else begin
      o_addr = i_hl;
    end
  end

  assign o_wdata  = (i_op == cpu_isa_pkg::OP_LD_HL_N) ? imm_lo : i_rd_b;
  assign o_opcode = ir;

  // port a feeds register results, port b feeds store data.
  assign o_rd_a_sel = (i_op == cpu_isa_pkg::OP_INC_R || i_op == cpu_isa_pkg::OP_DEC_R) ?
                      i_dst : i_src;
  assign o_rd_b_sel = (i_op == cpu_isa_pkg::OP_LD_NN_A) ? cpu_isa_pkg::A : i_src;

  always_comb begin
    o_wr_en   = 1'b0;
    o_wr_data = i_rd_a;
    if (state == cpu_core_pkg::S_WRITEBACK) begin
      case (i_op)
        cpu_isa_pkg::OP_LD_R_R: o_wr_en = 1'b1;
        cpu_isa_pkg::OP_LD_R_N: begin
          o_wr_en   = 1'b1;
          o_wr_data = imm_lo;
        end
        cpu_isa_pkg::OP_LD_R_HL, cpu_isa_pkg::OP_LD_A_NN: begin
          o_wr_en   = 1'b1;
          o_wr_data = i_rdata;
        end
        cpu_isa_pkg::OP_INC_R: begin
          o_wr_en   = 1'b1;
          o_wr_data = i_rd_a + 8'd1;
        end
        cpu_isa_pkg::OP_DEC_R: begin
          o_wr_en   = 1'b1;
          o_wr_data = i_rd_a - 8'd1;
        end
        default: o_wr_en = 1'b0;
      endcase
    end
  end

  // the dst field of 0xfa already names A.
  assign o_wr_sel       = i_dst;
  assign o_pair_wr_en   = (state == cpu_core_pkg::S_WRITEBACK) &&
                          (i_op == cpu_isa_pkg::OP_LD_RR_NN);
  assign o_pair_sel     = i_pair;
  assign o_pair_wr_data = {imm_hi, imm_lo};

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state <= cpu_core_pkg::S_FETCH;
      busy  <= 1'b0;
      pc    <= `CPU_RESET_PC;
      ir    <= '0;
    end else begin
      if (o_start) begin
        busy <= 1'b1;
      end else if (i_done) begin
        busy <= 1'b0;
      end
      case (state)
        cpu_core_pkg::S_FETCH: begin
          if (i_done) begin
            ir    <= i_rdata;
            pc    <= pc + 16'd1;
            state <= cpu_core_pkg::S_DECODE;
          end
        end
        cpu_core_pkg::S_DECODE: begin
          case (i_op)
            cpu_isa_pkg::OP_LD_R_N, cpu_isa_pkg::OP_LD_HL_N:
              state <= cpu_core_pkg::S_IMM;
            cpu_isa_pkg::OP_LD_RR_NN, cpu_isa_pkg::OP_LD_A_NN, cpu_isa_pkg::OP_LD_NN_A:
              state <= cpu_core_pkg::S_IMM_LO;
            cpu_isa_pkg::OP_LD_R_HL, cpu_isa_pkg::OP_LD_HL_R:
              state <= cpu_core_pkg::S_MEM;
            cpu_isa_pkg::OP_LD_R_R, cpu_isa_pkg::OP_INC_R, cpu_isa_pkg::OP_DEC_R:
              state <= cpu_core_pkg::S_WRITEBACK;
            default: state <= cpu_core_pkg::S_FETCH;
          endcase
        end
        cpu_core_pkg::S_IMM: begin
          if (i_done) begin
            pc    <= pc + 16'd1;
            state <= (i_op == cpu_isa_pkg::OP_LD_HL_N) ? cpu_core_pkg::S_MEM :
                                                         cpu_core_pkg::S_WRITEBACK;
          end
        end
        cpu_core_pkg::S_IMM_LO: begin
          if (i_done) begin
            pc    <= pc + 16'd1;
            state <= cpu_core_pkg::S_IMM_HI;
          end
        end
        cpu_core_pkg::S_IMM_HI: begin
          if (i_done) begin
            pc    <= pc + 16'd1;
            state <= (i_op == cpu_isa_pkg::OP_LD_RR_NN) ? cpu_core_pkg::S_WRITEBACK :
                                                          cpu_core_pkg::S_MEM;
          end
        end
        cpu_core_pkg::S_MEM: begin
          // loads still need a register write, stores are finished.
          if (i_done) begin
            state <= store_op ? cpu_core_pkg::S_FETCH : cpu_core_pkg::S_WRITEBACK;
          end
        end
        default: state <= cpu_core_pkg::S_FETCH;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_done && (state == cpu_core_pkg::S_IMM || state == cpu_core_pkg::S_IMM_LO)) begin
      imm_lo <= i_rdata;
    end
    if (i_done && state == cpu_core_pkg::S_IMM_HI) begin
      imm_hi <= i_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== cpu_bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_master (
  input  wire                i_clk,
  input  wire                i_rst,
  input  wire                i_start,
  input  wire                i_we,
  input  cpu_isa_pkg::word_t i_addr,
  input  cpu_isa_pkg::byte_t i_wdata,
  output logic               o_done,
  output cpu_isa_pkg::byte_t o_rdata,
  output logic               o_mem_req,
  input  wire                i_mem_ack,
  output logic               o_mem_we,
  output cpu_isa_pkg::word_t o_mem_addr,
  output cpu_isa_pkg::byte_t o_mem_wdata,
  input  cpu_isa_pkg::byte_t i_mem_rdata
);

  cpu_core_pkg::bus_phase_t phase;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      phase     <= cpu_core_pkg::BP_IDLE;
      o_mem_req <= 1'b0;
      o_mem_we  <= 1'b0;
      o_done    <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (phase)
        cpu_core_pkg::BP_IDLE: begin
          if (i_start) begin
            o_mem_req <= 1'b1;
            o_mem_we  <= i_we;
            phase     <= cpu_core_pkg::BP_REQ;
          end
        end
        cpu_core_pkg::BP_REQ: begin
          if (i_mem_ack) begin
            o_mem_req <= 1'b0;
            o_mem_we  <= 1'b0;
            phase     <= cpu_core_pkg::BP_RELEASE;
          end
        end
        cpu_core_pkg::BP_RELEASE: begin
          // wait for the memory to let go of ack.
          if (!i_mem_ack) begin
            o_done <= 1'b1;
            phase  <= cpu_core_pkg::BP_IDLE;
          end
        end
        default: phase <= cpu_core_pkg::BP_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (phase == cpu_core_pkg::BP_IDLE && i_start) begin
      o_mem_addr  <= i_addr;
      o_mem_wdata <= i_wdata;
    end
    if (phase == cpu_core_pkg::BP_REQ && i_mem_ack) begin
      o_rdata <= i_mem_rdata;
    end
  end

  a_addr_stable: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (o_mem_req && $past(o_mem_req)) |-> $stable(o_mem_addr)
  );

  a_req_rise_ack_low: assert property (
    @(posedge i_clk) disable iff (i_rst)
    $rose(o_mem_req) |-> !$past(i_mem_ack)
  );

endmodule

`default_nettype wire

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_regfile (
  input  wire                    i_clk,
  input  wire                    i_rst,
  input  cpu_isa_pkg::reg_idx_t  i_rd_a_sel,
  input  cpu_isa_pkg::reg_idx_t  i_rd_b_sel,
  input  wire                    i_wr_en,
  input  cpu_isa_pkg::reg_idx_t  i_wr_sel,
  input  cpu_isa_pkg::byte_t     i_wr_data,
  input  wire                    i_pair_wr_en,
  input  cpu_isa_pkg::pair_idx_t i_pair_sel,
  input  cpu_isa_pkg::word_t     i_pair_wr_data,
  output cpu_isa_pkg::byte_t     o_rd_a,
  output cpu_isa_pkg::byte_t     o_rd_b,
  output cpu_isa_pkg::word_t     o_hl
);

  cpu_isa_pkg::byte_t regs [`CPU_NUM_REGS];

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en && i_wr_sel != cpu_isa_pkg::M_HL) begin
      regs[i_wr_sel] <= i_wr_data;
    end else if (i_pair_wr_en && i_pair_sel != cpu_isa_pkg::SP_UNUSED) begin
      // high byte sits at the even index of each pair.
      regs[{i_pair_sel, 1'b0}] <= i_pair_wr_data[15:8];
      regs[{i_pair_sel, 1'b1}] <= i_pair_wr_data[7:0];
    end
  end

  // slot 6 is never written, so (HL) reads back as zero here.
  assign o_rd_a = regs[i_rd_a_sel];
  assign o_rd_b = regs[i_rd_b_sel];
  assign o_hl   = {regs[cpu_isa_pkg::H], regs[cpu_isa_pkg::L]};

  a_no_hl_slot_write: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_wr_en |-> i_wr_sel != cpu_isa_pkg::M_HL
  );

  a_one_write_port: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !(i_wr_en && i_pair_wr_en)
  );

endmodule

`default_nettype wire

// ==== cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
  input  cpu_isa_pkg::byte_t     i_opcode,
  output cpu_isa_pkg::op_t       o_op,
  output cpu_isa_pkg::reg_idx_t  o_dst,
  output cpu_isa_pkg::reg_idx_t  o_src,
  output cpu_isa_pkg::pair_idx_t o_pair
);

  assign o_dst  = cpu_isa_pkg::reg_idx_t'(i_opcode[5:3]);
  assign o_src  = cpu_isa_pkg::reg_idx_t'(i_opcode[2:0]);
  assign o_pair = cpu_isa_pkg::pair_idx_t'(i_opcode[5:4]);

  always_comb begin
    o_op = cpu_isa_pkg::OP_NOP;
    case (i_opcode[7:6])
      2'b00: begin
        if (i_opcode[2:0] == 3'b110) begin
          if (o_dst == cpu_isa_pkg::M_HL) begin
            o_op = cpu_isa_pkg::OP_LD_HL_N;
          end else begin
            o_op = cpu_isa_pkg::OP_LD_R_N;
          end
        end else if (i_opcode[2:0] == 3'b100 && o_dst != cpu_isa_pkg::M_HL) begin
          o_op = cpu_isa_pkg::OP_INC_R;
        end else if (i_opcode[2:0] == 3'b101 && o_dst != cpu_isa_pkg::M_HL) begin
          o_op = cpu_isa_pkg::OP_DEC_R;
        end else if (i_opcode[3:0] == 4'b0001 && o_pair != cpu_isa_pkg::SP_UNUSED) begin
          o_op = cpu_isa_pkg::OP_LD_RR_NN;
        end
      end
      2'b01: begin
        // 0x76 is halt, which sits in the load block.
        if (i_opcode == 8'h76) begin
          o_op = cpu_isa_pkg::OP_NOP;
        end else if (o_src == cpu_isa_pkg::M_HL) begin
          o_op = cpu_isa_pkg::OP_LD_R_HL;
        end else if (o_dst == cpu_isa_pkg::M_HL) begin
          o_op = cpu_isa_pkg::OP_LD_HL_R;
        end else begin
          o_op = cpu_isa_pkg::OP_LD_R_R;
        end
      end
      2'b11: begin
        if (i_opcode == 8'hEA) begin
          o_op = cpu_isa_pkg::OP_LD_NN_A;
        end else if (i_opcode == 8'hFA) begin
          o_op = cpu_isa_pkg::OP_LD_A_NN;
        end
      end
      default: o_op = cpu_isa_pkg::OP_NOP;
    endcase
  end

endmodule

`default_nettype wire

// ==== cpu_core_pkg.sv ====
`default_nettype none

package cpu_core_pkg;

  // instruction sequencer states.
  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_IMM,
    S_IMM_LO,
    S_IMM_HI,
    S_MEM,
    S_WRITEBACK
  } ctrl_state_t;

  // handshake phases of the memory bus master.
  typedef enum logic [1:0] {
    BP_IDLE,
    BP_REQ,
    BP_RELEASE
  } bus_phase_t;

endpackage

`default_nettype wire

// ==== cpu_isa_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpu_isa_pkg;

  typedef logic [`CPU_DATA_W-1:0] byte_t;
  typedef logic [`CPU_ADDR_W-1:0] word_t;

  // register field encoding, as found in opcode bits 5..3 and 2..0.
  typedef enum logic [2:0] {
    B    = 3'd0,
    C    = 3'd1,
    D    = 3'd2,
    E    = 3'd3,
    H    = 3'd4,
    L    = 3'd5,
    M_HL = 3'd6,
    A    = 3'd7
  } reg_idx_t;

  // pair field encoding, opcode bits 5..4.
  typedef enum logic [1:0] {
    BC        = 2'd0,
    DE        = 2'd1,
    HL        = 2'd2,
    SP_UNUSED = 2'd3
  } pair_idx_t;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_LD_R_R,
    OP_LD_R_N,
    OP_LD_R_HL,
    OP_LD_HL_R,
    OP_LD_HL_N,
    OP_LD_RR_NN,
    OP_LD_A_NN,
    OP_LD_NN_A,
    OP_INC_R,
    OP_DEC_R
  } op_t;

endpackage

`default_nettype wire

// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first instruction fetch after reset.
`define CPU_RESET_PC 16'h0100

// external bus widths.
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

// register index space, slot 6 stands for (HL) and holds no data.
`define CPU_NUM_REGS 8

`endif
